// File: verilog/rvseed_pkg.sv
package rvseed_pkg;

	// data path
	localparam int CPU_WIDTH      = 64;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int ALU_OP_WIDTH   = 5;

	// alu op codes, 0 is left unused
	localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD  = 5'd1;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB  = 5'd2;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_AND  = 5'd3;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_OR   = 5'd4;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR  = 5'd5;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL  = 5'd6;  // shift by src2[5:0]
	localparam logic [ALU_OP_WIDTH-1:0] ALU_SRL  = 5'd7;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_SRA  = 5'd8;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_SLT  = 5'd9;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTU = 5'd10;

	// load extension codes on expand_signed
	localparam logic [3:0] LD_B  = 4'd1;
	localparam logic [3:0] LD_H  = 4'd2;
	localparam logic [3:0] LD_W  = 4'd3;
	localparam logic [3:0] LD_D  = 4'd4;
	localparam logic [3:0] LD_BU = 4'd5;
	localparam logic [3:0] LD_HU = 4'd6;
	localparam logic [3:0] LD_WU = 4'd7;

	localparam logic [CPU_WIDTH-1:0] RESET_PC = 64'h0000_0000_8000_0000;

	// data ram, 64 doublewords = 512 bytes
	localparam int RAM_WORDS = 64;
	localparam int RAM_AW    = 6;

endpackage

// File: verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
	input  logic [rvseed_pkg::ALU_OP_WIDTH-1:0] alu_op_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]    alu_src1_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]    alu_src2_i,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]    alu_res_o
);

	logic [5:0] shamt;       // rv64 shift amount
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = alu_src2_i[5:0];
	assign lt_signed   = $signed(alu_src1_i) < $signed(alu_src2_i);
	assign lt_unsigned = alu_src1_i < alu_src2_i;

	always_comb begin
		case (alu_op_i)
			rvseed_pkg::ALU_ADD: begin
				alu_res_o = alu_src1_i + alu_src2_i;  // also load address
			end
			rvseed_pkg::ALU_SUB: begin
				alu_res_o = alu_src1_i - alu_src2_i;
			end
			rvseed_pkg::ALU_AND: begin
				alu_res_o = alu_src1_i & alu_src2_i;
			end
			rvseed_pkg::ALU_OR: begin
				alu_res_o = alu_src1_i | alu_src2_i;
			end
			rvseed_pkg::ALU_XOR: begin
				alu_res_o = alu_src1_i ^ alu_src2_i;
			end
			rvseed_pkg::ALU_SLL: begin
				alu_res_o = alu_src1_i << shamt;
			end
			rvseed_pkg::ALU_SRL: begin
				alu_res_o = alu_src1_i >> shamt;
			end
			rvseed_pkg::ALU_SRA: begin
				alu_res_o = $signed(alu_src1_i) >>> shamt;  // keeps sign bit
			end
			rvseed_pkg::ALU_SLT: begin
				alu_res_o = {{(rvseed_pkg::CPU_WIDTH-1){1'b0}}, lt_signed};
			end
			rvseed_pkg::ALU_SLTU: begin
				alu_res_o = {{(rvseed_pkg::CPU_WIDTH-1){1'b0}}, lt_unsigned};
			end
			default: begin
				alu_res_o = '0;  // unknown op
			end
		endcase
	end

endmodule

// File: verilog/ex_mem_regs.sv
`timescale 1ns/1ps

module ex_mem_regs (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  reg_wen_ex_mem_i,
	input  logic [rvseed_pkg::REG_ADDR_WIDTH-1:0] reg_waddr_ex_mem_i,
	input  logic [rvseed_pkg::ALU_OP_WIDTH-1:0]   alu_op_ex_mem_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_src1_ex_mem_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_src2_ex_mem_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_res_ex_mem_i,
	input  logic                                  s_flag_ex_mem_i,
	input  logic [31:0]                           s_imm_ex_mem_i,
	input  logic [7:0]                            wmask_ex_mem_i,
	input  logic [2:0]                            rd_buf_flag_ex_mem_i,
	input  logic [3:0]                            expand_signed_ex_mem_i,
	input  logic                                  ebreak_flag_ex_mem_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      pc_ex_mem_i,
	output logic                                  reg_wen_ex_mem_o,
	output logic [rvseed_pkg::REG_ADDR_WIDTH-1:0] reg_waddr_ex_mem_o,
	output logic [rvseed_pkg::ALU_OP_WIDTH-1:0]   alu_op_ex_mem_o,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_src1_ex_mem_o,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_src2_ex_mem_o,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_res_ex_mem_o,
	output logic                                  s_flag_ex_mem_o,
	output logic [31:0]                           s_imm_ex_mem_o,
	output logic [7:0]                            wmask_ex_mem_o,
	output logic [2:0]                            rd_buf_flag_ex_mem_o,
	output logic [3:0]                            expand_signed_ex_mem_o,
	output logic                                  ebreak_flag_ex_mem_o,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]      pc_ex_mem_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_wen_ex_mem_o       <= 1'b0;
			reg_waddr_ex_mem_o     <= '0;
			alu_op_ex_mem_o        <= '0;
			alu_src1_ex_mem_o      <= '0;
			alu_src2_ex_mem_o      <= '0;
			alu_res_ex_mem_o       <= '0;
			s_flag_ex_mem_o        <= 1'b0;
			s_imm_ex_mem_o         <= '0;
			wmask_ex_mem_o         <= '0;
			rd_buf_flag_ex_mem_o   <= '0;
			expand_signed_ex_mem_o <= '0;
			ebreak_flag_ex_mem_o   <= 1'b0;
			pc_ex_mem_o            <= rvseed_pkg::RESET_PC;  // boot address
		end else begin
			reg_wen_ex_mem_o       <= reg_wen_ex_mem_i;
			reg_waddr_ex_mem_o     <= reg_waddr_ex_mem_i;
			alu_op_ex_mem_o        <= alu_op_ex_mem_i;
			alu_src1_ex_mem_o      <= alu_src1_ex_mem_i;
			alu_src2_ex_mem_o      <= alu_src2_ex_mem_i;
			alu_res_ex_mem_o       <= alu_res_ex_mem_i;
			s_flag_ex_mem_o        <= s_flag_ex_mem_i;
			s_imm_ex_mem_o         <= s_imm_ex_mem_i;
			wmask_ex_mem_o         <= wmask_ex_mem_i;
			rd_buf_flag_ex_mem_o   <= rd_buf_flag_ex_mem_i;
			expand_signed_ex_mem_o <= expand_signed_ex_mem_i;
			ebreak_flag_ex_mem_o   <= ebreak_flag_ex_mem_i;
			pc_ex_mem_o            <= pc_ex_mem_i;
		end
	end

	// decoder contract seen by the memory stage
	a_store_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
		s_flag_ex_mem_o |-> !reg_wen_ex_mem_o);
	a_store_mask: assert property (@(posedge clk) disable iff (!rst_n)
		s_flag_ex_mem_o |-> wmask_ex_mem_o != 8'h00);
	// load address comes straight from the alu
	a_load_add: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_buf_flag_ex_mem_o != 3'd0) |-> alu_op_ex_mem_o == rvseed_pkg::ALU_ADD);

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
	input  logic                               s_flag_i,
	input  logic [31:0]                        s_imm_i,
	input  logic [7:0]                         wmask_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]   alu_src1_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]   alu_src2_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]   alu_res_i,
	input  logic [2:0]                         rd_buf_flag_i,
	output logic [rvseed_pkg::RAM_AW-1:0]      ram_addr_o,
	output logic                               ram_we_o,
	output logic [7:0]                         ram_be_o,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]   ram_wdata_o,
	output logic [2:0]                         byte_off_o
);

	logic [rvseed_pkg::CPU_WIDTH-1:0] store_addr;
	logic [rvseed_pkg::CPU_WIDTH-1:0] mem_addr;
	logic                             is_load;
	logic                             misaligned;

	// store address = rs1 + sext(imm)
	assign store_addr = alu_src1_i + {{(rvseed_pkg::CPU_WIDTH-32){s_imm_i[31]}}, s_imm_i};
	assign mem_addr   = s_flag_i ? store_addr : alu_res_i;
	assign is_load    = rd_buf_flag_i != 3'd0;

	// word index and byte lane
	assign ram_addr_o = mem_addr[rvseed_pkg::RAM_AW+2:3];
	assign byte_off_o = mem_addr[2:0];

	// lane shift of mask and data
	assign ram_we_o    = s_flag_i;
	assign ram_be_o    = s_flag_i ? (wmask_i << byte_off_o) : 8'h00;
	assign ram_wdata_o = alu_src2_i << {byte_off_o, 3'b000};

	// size taken from the mask, each wider size needs one more zero low bit
	assign misaligned = (wmask_i[1] & byte_off_o[0]) |
			    (wmask_i[3] & byte_off_o[1]) |
			    (wmask_i[7] & byte_off_o[2]);

	always_comb begin
		if (s_flag_i || is_load) begin
			a_aligned: assert final (!misaligned)
				else $error("misaligned access, mask %h offset %0d", wmask_i, byte_off_o);
		end
		a_one_access: assert final (!(s_flag_i && is_load))
			else $error("store and load in the same slot");
	end

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram (
	input  logic                             clk,
	input  logic [rvseed_pkg::RAM_AW-1:0]    addr_i,
	input  logic                             we_i,
	input  logic [7:0]                       be_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0] wdata_i,
	output logic [rvseed_pkg::CPU_WIDTH-1:0] rdata_o
);

	logic [rvseed_pkg::CPU_WIDTH-1:0] mem [rvseed_pkg::RAM_WORDS];

	// byte-lane write
	always_ff @(posedge clk) begin
		for (int i = 0; i < 8; i++) begin
			if (we_i && be_i[i]) begin
				mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
			end
		end
	end

	// registered read, old data on a same-edge write
	always_ff @(posedge clk) begin
		rdata_o <= mem[addr_i];
	end

endmodule

// File: verilog/mem_wb_regs.sv
`timescale 1ns/1ps

module mem_wb_regs (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  reg_wen_i,
	input  logic [rvseed_pkg::REG_ADDR_WIDTH-1:0] reg_waddr_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_res_i,
	input  logic [2:0]                            rd_buf_flag_i,
	input  logic [3:0]                            expand_signed_i,
	input  logic [2:0]                            byte_off_i,
	input  logic                                  ebreak_flag_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      pc_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      ram_rdata_i,
	output logic                                  wb_wen_o,
	output logic [rvseed_pkg::REG_ADDR_WIDTH-1:0] wb_waddr_o,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]      wb_wdata_o,
	output logic                                  ebreak_o,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]      ebreak_pc_o
);

	localparam int W = rvseed_pkg::CPU_WIDTH;

	logic         load_q;
	logic [W-1:0] alu_res_q;
	logic [3:0]   expand_q;
	logic [2:0]   byte_off_q;
	logic [W-1:0] ld_data;
	logic [W-1:0] ld_ext;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_wen_o    <= 1'b0;
			load_q      <= 1'b0;
			ebreak_o    <= 1'b0;
			ebreak_pc_o <= rvseed_pkg::RESET_PC;
		end else begin
			wb_wen_o    <= reg_wen_i && (reg_waddr_i != '0);  // x0 stays zero
			load_q      <= rd_buf_flag_i != 3'd0;
			ebreak_o    <= ebreak_flag_i;
			ebreak_pc_o <= pc_i;
		end
	end

	always_ff @(posedge clk) begin
		wb_waddr_o <= reg_waddr_i;
		alu_res_q  <= alu_res_i;
		expand_q   <= expand_signed_i;
		byte_off_q <= byte_off_i;
	end

	// ram data already registered inside data_ram
	always_comb begin
		ld_data = ram_rdata_i >> {byte_off_q, 3'b000};
		case (expand_q)
			rvseed_pkg::LD_B:  ld_ext = {{(W-8){ld_data[7]}}, ld_data[7:0]};
			rvseed_pkg::LD_H:  ld_ext = {{(W-16){ld_data[15]}}, ld_data[15:0]};
			rvseed_pkg::LD_W:  ld_ext = {{(W-32){ld_data[31]}}, ld_data[31:0]};
			rvseed_pkg::LD_BU: ld_ext = {{(W-8){1'b0}}, ld_data[7:0]};
			rvseed_pkg::LD_HU: ld_ext = {{(W-16){1'b0}}, ld_data[15:0]};
			rvseed_pkg::LD_WU: ld_ext = {{(W-32){1'b0}}, ld_data[31:0]};
			default:           ld_ext = ld_data;  // LD_D
		endcase
	end

	assign wb_wdata_o = load_q ? ld_ext : alu_res_q;

endmodule

// File: verilog/rvseed_top.sv
`timescale 1ns/1ps

module rvseed_top (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  reg_wen_i,
	input  logic [rvseed_pkg::REG_ADDR_WIDTH-1:0] reg_waddr_i,
	input  logic [rvseed_pkg::ALU_OP_WIDTH-1:0]   alu_op_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_src1_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_src2_i,
	input  logic                                  s_flag_i,
	input  logic [31:0]                           s_imm_i,
	input  logic [7:0]                            wmask_i,
	input  logic [2:0]                            rd_buf_flag_i,
	input  logic [3:0]                            expand_signed_i,
	input  logic                                  ebreak_flag_i,
	input  logic [rvseed_pkg::CPU_WIDTH-1:0]      pc_i,
	output logic                                  wb_wen_o,
	output logic [rvseed_pkg::REG_ADDR_WIDTH-1:0] wb_waddr_o,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]      wb_wdata_o,
	output logic                                  ebreak_o,
	output logic [rvseed_pkg::CPU_WIDTH-1:0]      ebreak_pc_o
);

	logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_res_ex;
	// memory stage copies
	logic                                  reg_wen_mem;
	logic [rvseed_pkg::REG_ADDR_WIDTH-1:0] reg_waddr_mem;
	logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_src1_mem;
	logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_src2_mem;
	logic [rvseed_pkg::CPU_WIDTH-1:0]      alu_res_mem;
	logic                                  s_flag_mem;
	logic [31:0]                           s_imm_mem;
	logic [7:0]                            wmask_mem;
	logic [2:0]                            rd_buf_flag_mem;
	logic [3:0]                            expand_signed_mem;
	logic                                  ebreak_flag_mem;
	logic [rvseed_pkg::CPU_WIDTH-1:0]      pc_mem;
	// ram side
	logic [rvseed_pkg::RAM_AW-1:0]         ram_addr;
	logic                                  ram_we;
	logic [7:0]                            ram_be;
	logic [rvseed_pkg::CPU_WIDTH-1:0]      ram_wdata;
	logic [rvseed_pkg::CPU_WIDTH-1:0]      ram_rdata;
	logic [2:0]                            byte_off;

	ex_stage u_ex_stage (
		.alu_op_i   (alu_op_i),
		.alu_src1_i (alu_src1_i),
		.alu_src2_i (alu_src2_i),
		.alu_res_o  (alu_res_ex)
	);

	ex_mem_regs u_ex_mem_regs (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.reg_wen_ex_mem_i       (reg_wen_i),
		.reg_waddr_ex_mem_i     (reg_waddr_i),
		.alu_op_ex_mem_i        (alu_op_i),
		.alu_src1_ex_mem_i      (alu_src1_i),
		.alu_src2_ex_mem_i      (alu_src2_i),
		.alu_res_ex_mem_i       (alu_res_ex),
		.s_flag_ex_mem_i        (s_flag_i),
		.s_imm_ex_mem_i         (s_imm_i),
		.wmask_ex_mem_i         (wmask_i),
		.rd_buf_flag_ex_mem_i   (rd_buf_flag_i),
		.expand_signed_ex_mem_i (expand_signed_i),
		.ebreak_flag_ex_mem_i   (ebreak_flag_i),
		.pc_ex_mem_i            (pc_i),
		.reg_wen_ex_mem_o       (reg_wen_mem),
		.reg_waddr_ex_mem_o     (reg_waddr_mem),
		.alu_op_ex_mem_o        (),  // only checked inside the register
		.alu_src1_ex_mem_o      (alu_src1_mem),
		.alu_src2_ex_mem_o      (alu_src2_mem),
		.alu_res_ex_mem_o       (alu_res_mem),
		.s_flag_ex_mem_o        (s_flag_mem),
		.s_imm_ex_mem_o         (s_imm_mem),
		.wmask_ex_mem_o         (wmask_mem),
		.rd_buf_flag_ex_mem_o   (rd_buf_flag_mem),
		.expand_signed_ex_mem_o (expand_signed_mem),
		.ebreak_flag_ex_mem_o   (ebreak_flag_mem),
		.pc_ex_mem_o            (pc_mem)
	);

	mem_stage u_mem_stage (
		.s_flag_i      (s_flag_mem),
		.s_imm_i       (s_imm_mem),
		.wmask_i       (wmask_mem),
		.alu_src1_i    (alu_src1_mem),
		.alu_src2_i    (alu_src2_mem),
		.alu_res_i     (alu_res_mem),
		.rd_buf_flag_i (rd_buf_flag_mem),
		.ram_addr_o    (ram_addr),
		.ram_we_o      (ram_we),
		.ram_be_o      (ram_be),
		.ram_wdata_o   (ram_wdata),
		.byte_off_o    (byte_off)
	);

	data_ram u_data_ram (
		.clk     (clk),
		.addr_i  (ram_addr),
		.we_i    (ram_we),
		.be_i    (ram_be),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	mem_wb_regs u_mem_wb_regs (
		.clk             (clk),
		.rst_n           (rst_n),
		.reg_wen_i       (reg_wen_mem),
		.reg_waddr_i     (reg_waddr_mem),
		.alu_res_i       (alu_res_mem),
		.rd_buf_flag_i   (rd_buf_flag_mem),
		.expand_signed_i (expand_signed_mem),
		.byte_off_i      (byte_off),
		.ebreak_flag_i   (ebreak_flag_mem),
		.pc_i            (pc_mem),
		.ram_rdata_i     (ram_rdata),
		.wb_wen_o        (wb_wen_o),
		.wb_waddr_o      (wb_waddr_o),
		.wb_wdata_o      (wb_wdata_o),
		.ebreak_o        (ebreak_o),
		.ebreak_pc_o     (ebreak_pc_o)
	);

endmodule

// File: sim/tb_top.sv
`timescale 1ns/1ps

module tb_top;

	localparam int CLK_NS  = 8;
	localparam int N_INSTR = 161;  // fill 64, alu 31, store+load 30, loads 29, ebreak 3, flush 4

	typedef struct packed {
		logic        wen;
		logic [4:0]  waddr;
		logic [63:0] data;
		logic        ebrk;
		logic [63:0] pc;
	} wb_t;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        reg_wen_i;
	logic [4:0]  reg_waddr_i;
	logic [4:0]  alu_op_i;
	logic [63:0] alu_src1_i;
	logic [63:0] alu_src2_i;
	logic        s_flag_i;
	logic [31:0] s_imm_i;
	logic [7:0]  wmask_i;
	logic [2:0]  rd_buf_flag_i;
	logic [3:0]  expand_signed_i;
	logic        ebreak_flag_i;
	logic [63:0] pc_i;
	logic        wb_wen_o;
	logic [4:0]  wb_waddr_o;
	logic [63:0] wb_wdata_o;
	logic        ebreak_o;
	logic [63:0] ebreak_pc_o;

	integer     seed = 18469;
	int         errors = 0;
	int         pc_cnt = 0;          // slots issued so far
	logic [7:0] mem_model [512];     // byte image of the data ram
	wb_t        h0, h1, chk;         // h0 newest and chk due at the outputs now

	logic [4:0] alu_ops [10] = '{rvseed_pkg::ALU_ADD, rvseed_pkg::ALU_SUB, rvseed_pkg::ALU_AND,
		rvseed_pkg::ALU_OR, rvseed_pkg::ALU_XOR, rvseed_pkg::ALU_SLL, rvseed_pkg::ALU_SRL,
		rvseed_pkg::ALU_SRA, rvseed_pkg::ALU_SLT, rvseed_pkg::ALU_SLTU};
	logic [3:0] load_codes [7] = '{rvseed_pkg::LD_B, rvseed_pkg::LD_H, rvseed_pkg::LD_W,
		rvseed_pkg::LD_D, rvseed_pkg::LD_BU, rvseed_pkg::LD_HU, rvseed_pkg::LD_WU};

	always #(CLK_NS / 2) clk = ~clk;

	rvseed_top u_rvseed_top (.*);

	function automatic logic [63:0] alu_expect(logic [4:0] op, logic [63:0] a, logic [63:0] b);
		logic [5:0] sh;
		sh = b[5:0];
		case (op)
			rvseed_pkg::ALU_ADD:  return a + b;
			rvseed_pkg::ALU_SUB:  return a - b;
			rvseed_pkg::ALU_AND:  return a & b;
			rvseed_pkg::ALU_OR:   return a | b;
			rvseed_pkg::ALU_XOR:  return a ^ b;
			rvseed_pkg::ALU_SLL:  return a << sh;
			rvseed_pkg::ALU_SRL:  return a >> sh;
			// fill the vacated top bits with copies of the sign
			rvseed_pkg::ALU_SRA:  return (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'h0);
			rvseed_pkg::ALU_SLT:  return (a[63] != b[63]) ? {63'h0, a[63]} : {63'h0, a < b};
			rvseed_pkg::ALU_SLTU: return {63'h0, a < b};
			default:              return 64'h0;
		endcase
	endfunction

	function automatic int size_of(logic [3:0] code);
		if (code == rvseed_pkg::LD_B || code == rvseed_pkg::LD_BU) return 1;
		if (code == rvseed_pkg::LD_H || code == rvseed_pkg::LD_HU) return 2;
		if (code == rvseed_pkg::LD_W || code == rvseed_pkg::LD_WU) return 4;
		return 8;
	endfunction

	// little endian gather from the byte model, then extend
	function automatic logic [63:0] load_expect(int addr, logic [3:0] code);
		int          size;
		logic        sext;
		logic [63:0] v;
		size = size_of(code);
		sext = code == rvseed_pkg::LD_B || code == rvseed_pkg::LD_H || code == rvseed_pkg::LD_W;
		v    = 64'h0;
		for (int i = 0; i < size; i++)
			v[8*i +: 8] = mem_model[addr + i];
		if (sext && v[8*size-1]) begin
			for (int i = size; i < 8; i++)
				v[8*i +: 8] = 8'hff;
		end
		return v;
	endfunction

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic [63:0] rand_small();
		logic [31:0] r;
		r = $random(seed);
		return {{56{r[7]}}, r[7:0]};  // -128 .. 127
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [31:0] r;
		r = $random(seed);
		return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
	endfunction

	task automatic idle_inputs();
		{reg_wen_i, reg_waddr_i, alu_op_i, alu_src1_i, alu_src2_i, s_flag_i, s_imm_i,
			wmask_i, rd_buf_flag_i, expand_signed_i, ebreak_flag_i} = '0;
		pc_i = rvseed_pkg::RESET_PC + 64'(4 * pc_cnt);
	endtask

	// one issue slot and the history moves along by one
	task automatic next_slot();
		@(posedge clk);
		#1;
		chk    = h1;
		h1     = h0;
		pc_cnt = pc_cnt + 1;
		idle_inputs();
		h0 = '{wen: 1'b0, waddr: 5'd0, data: 64'h0, ebrk: 1'b0, pc: pc_i};
	endtask

	task automatic do_alu(logic [4:0] op, logic [4:0] rd, logic [63:0] a, logic [63:0] b);
		next_slot();
		reg_wen_i   = 1'b1;
		reg_waddr_i = rd;
		alu_op_i    = op;
		alu_src1_i  = a;
		alu_src2_i  = b;
		h0.wen      = rd != 5'd0;  // x0 never written
		h0.waddr    = rd;
		h0.data     = alu_expect(op, a, b);
	endtask

	task automatic do_store(int addr, int size, logic [63:0] data);
		logic [63:0] off;
		off = rand_small();
		next_slot();
		s_flag_i   = 1'b1;
		alu_op_i   = rvseed_pkg::ALU_ADD;
		alu_src1_i = 64'(addr) - off;  // base + imm lands on addr
		alu_src2_i = data;
		s_imm_i    = off[31:0];
		wmask_i    = 8'((9'h1 << size) - 9'h1);
		for (int i = 0; i < size; i++)
			mem_model[addr + i] = data[8*i +: 8];
	endtask

	task automatic do_load(int addr, logic [3:0] code);
		logic [63:0] off;
		logic [4:0]  rd;
		off = rand_small();
		rd  = rand_reg();
		next_slot();
		reg_wen_i       = 1'b1;
		reg_waddr_i     = rd;
		alu_op_i        = rvseed_pkg::ALU_ADD;
		alu_src1_i      = 64'(addr) - off;
		alu_src2_i      = off;
		wmask_i         = 8'((9'h1 << size_of(code)) - 9'h1);  // access size
		rd_buf_flag_i   = 3'd1;
		expand_signed_i = code;
		h0.wen          = 1'b1;
		h0.waddr        = rd;
		h0.data         = load_expect(addr, code);
	endtask

	task automatic do_ebreak();
		next_slot();
		ebreak_flag_i = 1'b1;
		h0.ebrk       = 1'b1;
	endtask

	a_wen: assert property (@(posedge clk) disable iff (!rst_n) wb_wen_o == chk.wen)
		else begin
			errors++;
			$display("error: wb_wen_o is %h, expected %h", $sampled(wb_wen_o), chk.wen);
		end
	a_waddr: assert property (@(posedge clk) disable iff (!rst_n)
		chk.wen |-> wb_waddr_o == chk.waddr)
		else begin
			errors++;
			$display("error: wb_waddr_o is %h, expected %h", $sampled(wb_waddr_o), chk.waddr);
		end
	a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
		chk.wen |-> wb_wdata_o == chk.data)
		else begin
			errors++;
			$display("error: wb_wdata_o is %h, expected %h", $sampled(wb_wdata_o), chk.data);
		end
	a_ebreak: assert property (@(posedge clk) disable iff (!rst_n) ebreak_o == chk.ebrk)
		else begin
			errors++;
			$display("error: ebreak_o is %h, expected %h", $sampled(ebreak_o), chk.ebrk);
		end
	a_ebreak_pc: assert property (@(posedge clk) disable iff (!rst_n) ebreak_pc_o == chk.pc)
		else begin
			errors++;
			$display("error: ebreak_pc_o is %h, expected %h", $sampled(ebreak_pc_o), chk.pc);
		end

	initial begin
		int word;
		rst_n = 1'b0;
		idle_inputs();
		h0  = '{wen: 1'b0, waddr: 5'd0, data: 64'h0, ebrk: 1'b0, pc: rvseed_pkg::RESET_PC};
		h1  = h0;
		chk = h0;  // reset state of the outputs
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// fill every doubleword so no load sees an unwritten byte
		for (int w = 0; w < 64; w++)
			do_store(w * 8, 8, rand64());
		foreach (alu_ops[k])
			repeat (3) do_alu(alu_ops[k], rand_reg(), rand64(), rand64());
		do_alu(rvseed_pkg::ALU_ADD, 5'd0, rand64(), rand64());
		// each store size at each aligned offset and read back the very next cycle
		for (int size = 1; size <= 8; size = size * 2) begin
			for (int off = 0; off < 8; off += size) begin
				word = $random(seed) & 63;
				do_store(word * 8 + off, size, rand64());
				do_load(word * 8, rvseed_pkg::LD_D);
			end
		end
		foreach (load_codes[c]) begin
			for (int off = 0; off < 8; off += size_of(load_codes[c])) begin
				word = $random(seed) & 63;
				do_load(word * 8 + off, load_codes[c]);
			end
		end
		do_ebreak();
		next_slot();
		do_ebreak();
		repeat (4) next_slot();  // drain the pipeline
		$display("%0d instructions issued, %0d errors", pc_cnt, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#((N_INSTR + 20) * CLK_NS);
		$display("timeout: the run did not finish in time");
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: sim.f
verilog/rvseed_pkg.sv
verilog/ex_stage.sv
verilog/ex_mem_regs.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/mem_wb_regs.sv
verilog/rvseed_top.sv
sim/tb_top.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --assert --top-module tb_top -f sim.f -o tb_top_sim \
	&& ./obj_dir/tb_top_sim)
echo "$out"
echo "$out" | grep -qx "All tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
